/* bench/fdd_buffer_model.sv */
// Floppy controller sector buffer model for the SD card subsystem testbench.
// 512 bytes behind the byte-wide slave port, read data valid the cycle after read.
// Backdoor tasks load and inspect bytes without bus cycles.
`timescale 1ns/10ps

module fdd_buffer_model (
   input  logic       clk,
   input  logic [8:0] address,     // byte in buffer
   input  logic       read,
   input  logic       write,
   input  logic [7:0] writedata,
   output logic [7:0] readdata     // one cycle after read
);

   logic [7:0] mem [512];
   logic [7:0] rdata_q;

   // bus side, writes land on the edge, reads come back registered
   always @(posedge clk) begin
      if (write) begin
         mem[address] <= writedata;
      end
      if (read) begin
         rdata_q <= mem[address];
      end
   end

   assign readdata = rdata_q;

   // backdoor load, no clock needed
   task automatic poke_byte(input logic [8:0] addr, input logic [7:0] data);
      mem[addr] = data;
   endtask

   // backdoor inspect
   task automatic peek_byte(input logic [8:0] addr, output logic [7:0] data);
      data = mem[addr];
   endtask

endmodule

/* bench/tb_sd_card_subsystem.sv */
// Testbench for the SD card subsystem. Drives the host master port, models the
// floppy buffer on the slave port and checks both transfer directions against
// a shadow copy of the card store kept here.
`timescale 1ns/10ps

module tb_sd_card_subsystem;
   import sd_pkg::*;

   localparam int sectors     = 16;
   localparam int store_size  = sectors * sector_bytes;
   localparam int poll_limit  = 2000;    // control polls before giving up
   localparam int valid_limit = 8;       // cycles to wait for readdatavalid

   // expected effect of byte k of a run
   typedef struct packed {
      logic [8:0]  fdd_addr;
      logic [31:0] card_addr;
      logic [7:0]  data;
   } ref_t;

   logic        clk;
   logic        rst;
   logic [31:0] mst_address;
   logic        mst_waitrequest;
   logic        mst_read;
   logic        mst_readdatavalid;
   logic [31:0] mst_readdata;
   logic        mst_write;
   logic [31:0] mst_writedata;
   logic [8:0]  slv_address;
   logic        slv_read;
   logic [7:0]  slv_readdata;
   logic        slv_write;
   logic [7:0]  slv_writedata;

   logic [31:0] lfsr_q;
   logic        rd_seen;                 // read strobe seen at last rising edge
   logic [7:0]  card_shadow [store_size];
   logic [7:0]  buf_exp [512];
   int          value_errs;
   int          proto_errs;
   int          timeout_errs;

   sd_card_subsystem #(.sector_count(sectors)) u_sd_card_subsystem (
      .clk                     (clk),
      .rst                     (rst),
      .sd_master_address       (mst_address),
      .sd_master_waitrequest   (mst_waitrequest),
      .sd_master_read          (mst_read),
      .sd_master_readdatavalid (mst_readdatavalid),
      .sd_master_readdata      (mst_readdata),
      .sd_master_write         (mst_write),
      .sd_master_writedata     (mst_writedata),
      .sd_slave_address        (slv_address),
      .sd_slave_read           (slv_read),
      .sd_slave_readdata       (slv_readdata),
      .sd_slave_write          (slv_write),
      .sd_slave_writedata      (slv_writedata)
   );

   fdd_buffer_model u_fdd (
      .clk       (clk),
      .address   (slv_address),
      .read      (slv_read),
      .write     (slv_write),
      .writedata (slv_writedata),
      .readdata  (slv_readdata)
   );

   always #10 clk = ~clk;                // 20 ns period

   task automatic check_word(input string name, input logic [31:0] got, exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_byte(input logic [8:0] addr, input logic [7:0] got, exp);
      if (got !== exp) begin
         $display("ERR %0t fdd_buf[%03h] got %02h expected %02h", $time, addr, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         value_errs++;
      end
   endtask

   // readdatavalid mirrors the read strobe one cycle later and waitrequest stays low
   always @(posedge clk) begin
      rd_seen <= rst ? 1'b0 : mst_read;
   end

   always @(negedge clk) begin
      if (!rst) begin
         check_flag("sd_master_readdatavalid", mst_readdatavalid, rd_seen);
         check_flag("sd_master_waitrequest", mst_waitrequest, 1'b0);
      end
   end

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);     // one step per bit
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   // buffer address, card address and moved byte for byte k of a run
   function automatic ref_t transfer_ref(input logic [31:0] ctrl, base, sector, input int k);
      ref_t r;
      r.fdd_addr  = 9'((base + k) % sector_bytes);
      r.card_addr = (sector * sector_bytes + k) % store_size;
      if (ctrl == ctrl_card_to_fdd) begin
         r.data = card_shadow[r.card_addr];
      end else begin
         r.data = buf_exp[r.fdd_addr];
      end
      return r;
   endfunction

   // replays a run on the shadow copies in byte order so later bytes overwrite
   task automatic apply_ref(input logic [31:0] ctrl, base, sector, count);
      ref_t r;
      int   n;
      n = count * sector_bytes;
      for (int k = 0; k < n; k++) begin
         r = transfer_ref(ctrl, base, sector, k);
         if (ctrl == ctrl_card_to_fdd) begin
            buf_exp[r.fdd_addr] = r.data;
         end else begin
            card_shadow[r.card_addr] = r.data;
         end
      end
   endtask

   task automatic host_write(input logic [31:0] addr, data);
      @(negedge clk);
      mst_address   = addr;
      mst_writedata = data;
      mst_write     = 1'b1;
      @(negedge clk);
      mst_write     = 1'b0;
   endtask

   task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      mst_address = addr;
      mst_read    = 1'b1;
      @(negedge clk);
      mst_read    = 1'b0;
      while (!mst_readdatavalid && waited < valid_limit) begin
         @(negedge clk);
         waited++;
      end
      if (!mst_readdatavalid) begin
         $display("timeout: no read data returned for register offset %0d", addr);
         timeout_errs++;
      end else if (waited != 0) begin
         $display("read data for offset %0d came %0d cycles late", addr, waited);
         proto_errs++;
      end
      data = mst_readdata;
   endtask

   task automatic wait_idle(input string what);
      logic [31:0] v;
      int          polls;
      polls = 0;
      v     = 32'hffff_ffff;
      while (v !== ctrl_idle && polls < poll_limit) begin
         host_read(reg_ctrl_addr, v);
         polls++;
      end
      if (v !== ctrl_idle) begin
         $display("timeout: control never returned to idle during %s", what);
         timeout_errs++;
      end
   endtask

   task automatic check_buffer();
      logic [7:0] b;
      for (int a = 0; a < 512; a++) begin
         u_fdd.peek_byte(9'(a), b);
         check_byte(9'(a), b, buf_exp[a]);
      end
   endtask

   task automatic fill_buffer();
      logic [31:0] v;
      for (int a = 0; a < 512; a++) begin
         rand_bits(8, v);
         u_fdd.poke_byte(9'(a), v[7:0]);
         buf_exp[a] = v[7:0];
      end
   endtask

   // program, launch, poll, then compare the buffer with the reference
   task automatic run_transfer(input logic [31:0] ctrl, base, sector, count, input string what);
      host_write(reg_base_addr, base);
      host_write(reg_sector_addr, sector);
      host_write(reg_count_addr, count);
      host_write(reg_ctrl_addr, ctrl);
      wait_idle(what);
      apply_ref(ctrl, base, sector, count);
      check_buffer();
   endtask

   initial begin
      logic [31:0] v;
      logic [31:0] rb;
      logic [31:0] rs;
      logic [31:0] rc;
      logic [31:0] base_b;
      clk           = 1'b0;
      rst           = 1'b1;
      mst_address   = '0;
      mst_read      = 1'b0;
      mst_write     = 1'b0;
      mst_writedata = '0;
      lfsr_q        = 32'h7dee_184b;
      value_errs    = 0;
      proto_errs    = 0;
      timeout_errs  = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // registers come out of reset at 0
      host_read(reg_base_addr, v);
      check_word("base", v, 32'd0);
      host_read(reg_sector_addr, v);
      check_word("sector", v, 32'd0);
      host_read(reg_count_addr, v);
      check_word("count", v, 32'd0);
      host_read(reg_ctrl_addr, v);
      check_word("ctrl", v, ctrl_idle);

      // random values read back and unmapped offsets read 0
      rand_bits(32, rb);
      rand_bits(32, rs);
      rand_bits(32, rc);
      host_write(reg_base_addr, rb);
      host_write(reg_sector_addr, rs);
      host_write(reg_count_addr, rc);
      host_write(32'd16, 32'hdead_beef);
      host_read(reg_base_addr, v);
      check_word("base", v, rb);
      host_read(reg_sector_addr, v);
      check_word("sector", v, rs);
      host_read(reg_count_addr, v);
      check_word("count", v, rc);
      host_read(32'd16, v);
      check_word("unmapped 16", v, 32'd0);
      host_read(32'd5, v);
      check_word("unmapped 5", v, 32'd0);

      // buffer to card and back with a wrapping base
      fill_buffer();
      run_transfer(ctrl_fdd_to_card, 32'd0, 32'd5, 32'd2, "buffer to card");
      fill_buffer();                     // sector 6 differs from sector 5
      run_transfer(ctrl_fdd_to_card, 32'd0, 32'd6, 32'd1, "second sector");
      rand_bits(9, v);
      base_b = {23'd0, v[8:0]} | 32'd1;
      run_transfer(ctrl_card_to_fdd, base_b, 32'd5, 32'd2, "card to buffer");

      // empty run leaves the buffer alone
      run_transfer(ctrl_card_to_fdd, base_b, 32'd3, 32'd0, "zero count");

      // sector range past store end wraps to sector 0
      fill_buffer();
      run_transfer(ctrl_fdd_to_card, 32'd7, 32'd15, 32'd2, "wrap write");
      fill_buffer();                     // sector 16 lands on sector 0
      run_transfer(ctrl_fdd_to_card, 32'd7, 32'd16, 32'd1, "wrap sector 0");
      run_transfer(ctrl_card_to_fdd, 32'h1f0, 32'd31, 32'd2, "wrap read");

      $display("errors: %0d value, %0d protocol, %0d timeout",
               value_errs, proto_errs, timeout_errs);
      if (value_errs + proto_errs + timeout_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* files.f */
source/sd_pkg.sv
source/sd_ctrl_regs.sv
source/sd_sector_engine.sv
source/sd_card_store.sv
source/sd_card_subsystem.sv
bench/fdd_buffer_model.sv
bench/tb_sd_card_subsystem.sv

/* source/sd_card_store.sv */
// Byte-wide sector memory standing in for the SD card.
// Single port, synchronous write, read data registered and valid next cycle.
`timescale 1ns/10ps

module sd_card_store #(
   parameter int sector_count = 16           // sectors held
) (
   input  logic              clk,
   input  sd_pkg::card_req_t card_req,
   input  logic              card_valid,
   output logic [7:0]        card_rdata
);
   import sd_pkg::*;

   localparam int store_bytes = sector_count * sector_bytes;
   localparam int local_aw    = calc_store_aw(sector_count);

   logic [7:0]          mem [store_bytes];
   logic [7:0]          rdata_q;
   logic [local_aw-1:0] idx;

   assign idx = card_req.addr[local_aw-1:0];   // engine already wraps the address

   // read data holds on a write cycle
   always_ff @(posedge clk) begin
      if (card_valid) begin
         if (card_req.we) begin
            mem[idx] <= card_req.wdata;
         end else begin
            rdata_q <= mem[idx];
         end
      end
   end

   assign card_rdata = rdata_q;

   a_addr_known : assert property (
      @(posedge clk)
      card_valid |-> !$isunknown(card_req.addr)
   ) else $error("card store access with unknown address");

endmodule

/* source/sd_card_subsystem.sv */
// Top level of the SD card side of the floppy subsystem.
// Host master port reaches the register file, the floppy buffer hangs off the
// byte-wide slave port. sector_count sizes the card store.
`timescale 1ns/10ps

module sd_card_subsystem #(
   parameter int sector_count = 16            // card store size in sectors
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] sd_master_address,
   output logic        sd_master_waitrequest,
   input  logic        sd_master_read,
   output logic        sd_master_readdatavalid,
   output logic [31:0] sd_master_readdata,
   input  logic        sd_master_write,
   input  logic [31:0] sd_master_writedata,
   output logic [8:0]  sd_slave_address,
   output logic        sd_slave_read,
   input  logic [7:0]  sd_slave_readdata,
   output logic        sd_slave_write,
   output logic [7:0]  sd_slave_writedata
);
   import sd_pkg::*;

   sd_regs_t   regs;
   card_req_t  card_req;
   logic       card_valid;
   logic [7:0] card_rdata;
   logic       start;
   logic       busy;
   logic       done;

   assign sd_master_waitrequest = 1'b0;   // host never stalled

   sd_ctrl_regs u_sd_ctrl_regs (
      .clk           (clk),
      .rst           (rst),
      .address       (sd_master_address),
      .read          (sd_master_read),
      .write         (sd_master_write),
      .writedata     (sd_master_writedata),
      .readdata      (sd_master_readdata),
      .readdatavalid (sd_master_readdatavalid),
      .regs          (regs),
      .start         (start),
      .busy          (busy),
      .done          (done)
   );

   sd_sector_engine #(
      .sector_count (sector_count)
   ) u_sd_sector_engine (
      .clk             (clk),
      .rst             (rst),
      .regs            (regs),
      .start           (start),
      .done            (done),
      .busy            (busy),
      .card_req        (card_req),
      .card_valid      (card_valid),
      .card_rdata      (card_rdata),
      .slave_address   (sd_slave_address),
      .slave_read      (sd_slave_read),
      .slave_write     (sd_slave_write),
      .slave_writedata (sd_slave_writedata),
      .slave_readdata  (sd_slave_readdata)
   );

   sd_card_store #(
      .sector_count (sector_count)
   ) u_sd_card_store (
      .clk        (clk),
      .card_req   (card_req),
      .card_valid (card_valid),
      .card_rdata (card_rdata)
   );

endmodule

/* source/sd_ctrl_regs.sv */
// Host register file for the SD card subsystem.
// Decodes master writes, returns registered read data one cycle after a read,
// and turns a command write into a start pulse for the sector engine.
`timescale 1ns/10ps

module sd_ctrl_regs (
   input  logic             clk,
   input  logic             rst,
   input  logic [31:0]      address,        // word offset from host
   input  logic             read,
   input  logic             write,
   input  logic [31:0]      writedata,
   output logic [31:0]      readdata,
   output logic             readdatavalid,  // one cycle after read
   output sd_pkg::sd_regs_t regs,           // to engine
   output logic             start,          // one cycle command pulse
   output logic             busy,           // transfer in progress
   input  logic             done            // engine finished
);
   import sd_pkg::*;

   sd_regs_t    regs_q;
   logic [31:0] rdata_q;
   logic [31:0] rd_mux;
   logic        rvalid_q;
   logic        start_q;
   logic        busy_q;
   logic        wr_base;
   logic        wr_sector;
   logic        wr_count;
   logic        wr_ctrl;
   logic        ctrl_locked;
   logic        cmd_accept;
   logic        is_cmd;

   // write decode, full address compare so aliases are ignored
   assign wr_base   = write && (address == reg_base_addr);
   assign wr_sector = write && (address == reg_sector_addr);
   assign wr_count  = write && (address == reg_count_addr);
   assign wr_ctrl   = write && (address == reg_ctrl_addr);

   assign ctrl_locked = busy_q || start_q;          // run pending or active
   assign cmd_accept  = wr_ctrl && !ctrl_locked;
   assign is_cmd      = (writedata == ctrl_card_to_fdd) ||
                        (writedata == ctrl_fdd_to_card);

   // parameter registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         regs_q.base   <= '0;
         regs_q.sector <= '0;
         regs_q.count  <= '0;
      end else begin
         if (wr_base)   regs_q.base   <= writedata;
         if (wr_sector) regs_q.sector <= writedata;
         if (wr_count)  regs_q.count  <= writedata;
      end
   end

   // control register, cleared back to idle when the engine reports done
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         regs_q.ctrl <= ctrl_idle;
      end else if (done) begin
         regs_q.ctrl <= ctrl_idle;
      end else if (cmd_accept) begin
         regs_q.ctrl <= writedata;
      end
   end

   // start pulse and busy flag
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_q <= 1'b0;
         busy_q  <= 1'b0;
      end else begin
         start_q <= cmd_accept && is_cmd;  // only codes 2 and 3 launch
         if (done) begin
            busy_q <= 1'b0;
         end else if (start_q) begin
            busy_q <= 1'b1;                // raised the cycle after start
         end
      end
   end

   // read-back mux, unmapped offsets read 0
   always_comb begin
      case (address)
         reg_base_addr:   rd_mux = regs_q.base;
         reg_sector_addr: rd_mux = regs_q.sector;
         reg_count_addr:  rd_mux = regs_q.count;
         reg_ctrl_addr:   rd_mux = regs_q.ctrl;
         default:         rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdata_q  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= read;                 // single cycle valid
         if (read) rdata_q <= rd_mux;
      end
   end

   assign readdata      = rdata_q;
   assign readdatavalid = rvalid_q;
   assign regs          = regs_q;
   assign start         = start_q;
   assign busy          = busy_q;

   // host must poll control back to idle before issuing another command
   a_no_ctrl_write_busy : assert property (
      @(posedge clk) disable iff (rst)
      (write && (address == reg_ctrl_addr)) |-> !(busy_q || start_q)
   ) else $error("control written while a transfer is running");

endmodule

/* source/sd_pkg.sv */
// Shared register map, control codes and bus structs for the SD card subsystem.
// Import into any module that decodes host registers or talks to the card store.
package sd_pkg;

   // host register offsets on the 32-bit master address
   localparam logic [31:0] reg_base_addr   = 32'd0;   // floppy buffer base
   localparam logic [31:0] reg_sector_addr = 32'd4;   // first card sector
   localparam logic [31:0] reg_count_addr  = 32'd8;   // block count
   localparam logic [31:0] reg_ctrl_addr   = 32'd12;  // command / status

   // control register codes
   localparam logic [31:0] ctrl_idle        = 32'd0;  // no transfer running
   localparam logic [31:0] ctrl_card_to_fdd = 32'd2;  // card store -> floppy buffer
   localparam logic [31:0] ctrl_fdd_to_card = 32'd3;  // floppy buffer -> card store

   localparam int sector_bytes = 512;                 // bytes per sector
   localparam int sector_aw    = $clog2(sector_bytes); // byte offset bits in a sector

   // upper bound on the sector_count module parameter
   localparam int max_sector_count = 4096;

   // byte address width of a store holding the given number of sectors
   function automatic int calc_store_aw(input int sectors);
      return $clog2(sectors * sector_bytes);
   endfunction

   localparam int store_aw = calc_store_aw(max_sector_count);  // widest store address

   typedef logic [store_aw-1:0] card_addr_t;

   // host visible register file, driven by sd_ctrl_regs
   typedef struct packed {
      logic [31:0] base;    // floppy buffer start address
      logic [31:0] sector;  // first card sector
      logic [31:0] count;   // sectors to move
      logic [31:0] ctrl;    // command code
   } sd_regs_t;

   // one card store access, driven by the sector engine
   typedef struct packed {
      card_addr_t  addr;   // byte address, upper bits beyond store size are 0
      logic        we;     // 1 = write, 0 = read
      logic [7:0]  wdata;  // write byte
   } card_req_t;

endpackage

/* source/sd_sector_engine.sv */
// Byte transfer sequencer between the card store and the floppy buffer port.
// One address per cycle on the source side, each returned byte is written to
// the other side the next cycle. Pulses done when the last byte has landed.
`timescale 1ns/10ps

module sd_sector_engine #(
   parameter int sector_count = 16       // sectors in the card store
) (
   input  logic              clk,
   input  logic              rst,
   input  sd_pkg::sd_regs_t  regs,            // latched on start
   input  logic              start,
   output logic              done,            // one cycle pulse
   input  logic              busy,            // from register file
   output sd_pkg::card_req_t card_req,
   output logic              card_valid,
   input  logic [7:0]        card_rdata,      // valid cycle after read
   output logic [8:0]        slave_address,   // floppy buffer byte
   output logic              slave_read,
   output logic              slave_write,
   output logic [7:0]        slave_writedata,
   input  logic [7:0]        slave_readdata   // valid cycle after read
);
   import sd_pkg::*;

   // wrap mask for the card byte address
   localparam card_addr_t store_mask = card_addr_t'(sector_count * sector_bytes - 1);

   typedef enum logic [1:0] {
      st_idle,   // waiting for start
      st_issue,  // one source read per cycle
      st_drain   // last byte still in flight
   } state_t;

   state_t                    state_q;
   logic                      to_card_q;       // 1 = buffer -> card
   logic [32+sector_aw-1:0]   left_q;          // bytes left to issue after this one
   logic                      pipe_v_q;        // returned byte present this cycle
   logic                      done_q;
   logic                      issuing;
   card_addr_t                card_addr_q;     // issue side card address
   logic [8:0]                fdd_addr_q;      // issue side buffer address
   card_addr_t                pipe_card_q;     // address of byte in flight
   logic [8:0]                pipe_fdd_q;

   assign issuing = (state_q == st_issue);

   // control path
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= st_idle;
         to_card_q <= 1'b0;
         left_q    <= '0;
         pipe_v_q  <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            st_idle: begin
               pipe_v_q <= 1'b0;
               if (start) begin
                  to_card_q <= (regs.ctrl == ctrl_fdd_to_card);
                  if (regs.count == '0) begin
                     done_q <= 1'b1;          // empty run finishes at once
                  end else begin
                     left_q  <= {regs.count, {sector_aw{1'b0}}} - 1'b1;
                     state_q <= st_issue;
                  end
               end
            end
            st_issue: begin
               pipe_v_q <= 1'b1;
               if (left_q == '0) begin
                  state_q <= st_drain;
               end else begin
                  left_q <= left_q - 1'b1;
               end
            end
            st_drain: begin
               pipe_v_q <= 1'b0;              // final write happens now
               done_q   <= 1'b1;
               state_q  <= st_idle;
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // address counters and in-flight address stage
   always_ff @(posedge clk) begin
      if (state_q == st_idle) begin
         card_addr_q <= card_addr_t'({regs.sector, {sector_aw{1'b0}}}) & store_mask;
         fdd_addr_q  <= regs.base[8:0];
      end else if (issuing) begin
         card_addr_q <= (card_addr_q + 1'b1) & store_mask;  // wraps at store end
         fdd_addr_q  <= fdd_addr_q + 1'b1;                  // wraps at 512
      end
      pipe_card_q <= card_addr_q;
      pipe_fdd_q  <= fdd_addr_q;
   end

   // port steering by direction
   always_comb begin
      card_req        = '0;
      card_valid      = 1'b0;
      slave_address   = '0;
      slave_read      = 1'b0;
      slave_write     = 1'b0;
      slave_writedata = '0;
      if (to_card_q) begin
         slave_read     = issuing;            // read buffer
         slave_address  = fdd_addr_q;
         card_valid     = pipe_v_q;           // write returned byte into store
         card_req.addr  = pipe_card_q;
         card_req.we    = pipe_v_q;
         card_req.wdata = slave_readdata;
      end else begin
         card_valid      = issuing;           // read store
         card_req.addr   = card_addr_q;
         slave_write     = pipe_v_q;          // write returned byte to buffer
         slave_address   = pipe_fdd_q;
         slave_writedata = card_rdata;
      end
   end

   assign done = done_q;

   a_slave_rd_wr_excl : assert property (
      @(posedge clk) disable iff (rst)
      !(slave_read && slave_write)
   ) else $error("slave read and write driven together");

   // register file must not launch a second run over this one
   a_start_not_busy : assert property (
      @(posedge clk) disable iff (rst)
      start |-> (!busy && (state_q == st_idle))
   ) else $error("start received while busy");

endmodule
